//--- hw/pipe_pkg.sv
package pipe_pkg;

    // data, address and result width
    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    // one strobe bit per byte of a double word
    typedef logic [7:0]  strb_t;
    typedef logic [1:0]  mem_size_t;

    localparam mem_size_t SIZE_B = 2'd0;
    localparam mem_size_t SIZE_H = 2'd1;
    localparam mem_size_t SIZE_W = 2'd2;
    localparam mem_size_t SIZE_D = 2'd3;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_LOAD  = 3'd5,
        OP_STORE = 3'd6
    } alu_op_t;

    localparam int RAM_WORDS_DEFAULT = 256;
    localparam int RD_LAT_DEFAULT    = 2;

    // byte lane of an access, low bits below the access size are dropped
    function automatic logic [2:0] lane_offset(input mem_size_t size, input logic [2:0] addr_lo);
        case (size)
            SIZE_B:  return addr_lo;
            SIZE_H:  return {addr_lo[2:1], 1'b0};
            SIZE_W:  return {addr_lo[2], 2'b00};
            default: return 3'd0;
        endcase
    endfunction

endpackage

//--- hw/ex_mem_if.sv
`timescale 1ns/100ps

interface ex_mem_if;

    logic                 valid;
    logic                 allowin;

    pipe_pkg::alu_op_t    op;
    // alu value, or the address for loads and stores
    pipe_pkg::xlen_t      result;
    // store data, already replicated across lanes
    pipe_pkg::xlen_t      st_data;
    pipe_pkg::strb_t      strb;
    pipe_pkg::mem_size_t  size;
    logic                 ld_unsigned;
    pipe_pkg::reg_addr_t  rd;
    logic                 reg_wen;

    modport producer (
        output valid,
        output op,
        output result,
        output st_data,
        output strb,
        output size,
        output ld_unsigned,
        output rd,
        output reg_wen,
        input  allowin
    );

    modport consumer (
        input  valid,
        input  op,
        input  result,
        input  st_data,
        input  strb,
        input  size,
        input  ld_unsigned,
        input  rd,
        input  reg_wen,
        output allowin
    );

endinterface

//--- hw/ex_stage.sv
`timescale 1ns/100ps

module ex_stage (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                in_valid,
    output logic                in_allowin,
    input  pipe_pkg::alu_op_t   in_op,
    input  pipe_pkg::xlen_t     in_rs1,
    input  pipe_pkg::xlen_t     in_rs2,
    input  pipe_pkg::xlen_t     in_imm,
    input  pipe_pkg::reg_addr_t in_rd,
    input  pipe_pkg::mem_size_t in_size,
    input  logic                in_unsigned,
    ex_mem_if.producer          ex_out
);

    logic                valid_q;
    pipe_pkg::alu_op_t   op_q;
    pipe_pkg::xlen_t     rs1_q;
    pipe_pkg::xlen_t     rs2_q;
    pipe_pkg::xlen_t     imm_q;
    pipe_pkg::reg_addr_t rd_q;
    pipe_pkg::mem_size_t size_q;
    logic                unsigned_q;

    pipe_pkg::xlen_t     addr;
    pipe_pkg::xlen_t     alu_res;
    pipe_pkg::xlen_t     st_data;
    pipe_pkg::strb_t     base_strb;
    logic [2:0]          offset;

    // empty, or the held op leaves this cycle
    assign in_allowin = !valid_q || ex_out.allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            valid_q <= 1'b0;
        end else if (in_allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (in_valid && in_allowin) begin
            op_q       <= in_op;
            rs1_q      <= in_rs1;
            rs2_q      <= in_rs2;
            imm_q      <= in_imm;
            rd_q       <= in_rd;
            size_q     <= in_size;
            unsigned_q <= in_unsigned;
        end
    end

    assign addr   = rs1_q + imm_q;
    assign offset = pipe_pkg::lane_offset(size_q, addr[2:0]);

    always_comb begin
        case (op_q)
            pipe_pkg::OP_ADD: alu_res = rs1_q + rs2_q;
            pipe_pkg::OP_SUB: alu_res = rs1_q - rs2_q;
            pipe_pkg::OP_AND: alu_res = rs1_q & rs2_q;
            pipe_pkg::OP_OR:  alu_res = rs1_q | rs2_q;
            pipe_pkg::OP_XOR: alu_res = rs1_q ^ rs2_q;
            // loads and stores carry the address
            default:          alu_res = addr;
        endcase
    end

    // store data repeated in every lane, strobe picks the lane
    always_comb begin
        case (size_q)
            pipe_pkg::SIZE_B: begin
                st_data   = {8{rs2_q[7:0]}};
                base_strb = 8'h01;
            end
            pipe_pkg::SIZE_H: begin
                st_data   = {4{rs2_q[15:0]}};
                base_strb = 8'h03;
            end
            pipe_pkg::SIZE_W: begin
                st_data   = {2{rs2_q[31:0]}};
                base_strb = 8'h0f;
            end
            default: begin
                st_data   = rs2_q;
                base_strb = 8'hff;
            end
        endcase
    end

    assign ex_out.valid       = valid_q;
    assign ex_out.op          = op_q;
    assign ex_out.result      = alu_res;
    assign ex_out.st_data     = st_data;
    assign ex_out.strb        = (op_q == pipe_pkg::OP_STORE) ? (base_strb << offset) : '0;
    assign ex_out.size        = size_q;
    assign ex_out.ld_unsigned = unsigned_q;
    assign ex_out.rd          = rd_q;
    assign ex_out.reg_wen     = (op_q != pipe_pkg::OP_STORE);

endmodule

//--- hw/ex_mem_reg.sv
`timescale 1ns/100ps

module ex_mem_reg (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    ex_mem_if.consumer      ex_in,
    ex_mem_if.producer      mem_out,
    output logic            rd_en,
    input  logic            rvalid,
    input  pipe_pkg::xlen_t rdata,
    output pipe_pkg::xlen_t load_data
);

    logic                input_valid;
    logic                output_valid;
    logic                capture;
    logic                is_load;
    logic                load_done;
    logic                load_pending;
    pipe_pkg::xlen_t     load_data_q;

    pipe_pkg::alu_op_t   op_q;
    pipe_pkg::xlen_t     result_q;
    pipe_pkg::xlen_t     st_data_q;
    pipe_pkg::strb_t     strb_q;
    pipe_pkg::mem_size_t size_q;
    logic                unsigned_q;
    pipe_pkg::reg_addr_t rd_q;
    logic                reg_wen_q;

    assign is_load      = (op_q == pipe_pkg::OP_LOAD);
    assign load_pending = input_valid && is_load && !load_done;

    // a load is ready on the rvalid pulse, and stays ready once done
    assign output_valid = !is_load || load_done || rvalid;

    assign ex_in.allowin = !input_valid || (output_valid && mem_out.allowin);
    assign mem_out.valid = input_valid && output_valid;
    assign capture       = ex_in.valid && ex_in.allowin;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            input_valid <= 1'b0;
        end else if (ex_in.allowin) begin
            input_valid <= ex_in.valid;
        end
    end

    // one cycle read pulse right after a load is taken
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            rd_en <= 1'b0;
        end else begin
            rd_en <= capture && (ex_in.op == pipe_pkg::OP_LOAD);
        end
    end

    // new capture wins over an rvalid that belongs to the op leaving
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            load_done <= 1'b0;
        end else if (capture) begin
            load_done <= 1'b0;
        end else if (rvalid) begin
            load_done <= 1'b1;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (rvalid) begin
            load_data_q <= rdata;
        end
    end

    assign load_data = load_done ? load_data_q : rdata;

    always_ff @(posedge I_sys_clk) begin
        if (capture) begin
            op_q       <= ex_in.op;
            result_q   <= ex_in.result;
            st_data_q  <= ex_in.st_data;
            strb_q     <= ex_in.strb;
            size_q     <= ex_in.size;
            unsigned_q <= ex_in.ld_unsigned;
            rd_q       <= ex_in.rd;
            reg_wen_q  <= ex_in.reg_wen;
        end
    end

    assign mem_out.op          = op_q;
    assign mem_out.result      = result_q;
    assign mem_out.st_data     = st_data_q;
    assign mem_out.strb        = strb_q;
    assign mem_out.size        = size_q;
    assign mem_out.ld_unsigned = unsigned_q;
    assign mem_out.rd          = rd_q;
    assign mem_out.reg_wen     = reg_wen_q;

    // read data only ever returns for the load held here
    a_rvalid_pending: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        rvalid |-> load_pending
    ) else $error("rvalid without a pending load");

    // stalled output keeps its op, address and load data
    a_stall_stable: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        mem_out.valid && !mem_out.allowin |=>
            mem_out.valid && $stable(op_q) && $stable(result_q) && $stable(load_data)
    ) else $error("EX/MEM payload changed under stall");

endmodule

//--- hw/data_ram.sv
`timescale 1ns/100ps

module data_ram #(
    parameter int RAM_WORDS = pipe_pkg::RAM_WORDS_DEFAULT,
    parameter int RD_LAT    = pipe_pkg::RD_LAT_DEFAULT
) (
    input  logic            I_sys_clk,
    input  logic            I_rst,
    input  logic            rd_en,
    input  pipe_pkg::xlen_t raddr,
    output logic            rvalid,
    output pipe_pkg::xlen_t rdata,
    input  logic            wen,
    input  pipe_pkg::xlen_t waddr,
    input  pipe_pkg::xlen_t wdata,
    input  pipe_pkg::strb_t strb
);

    localparam int IDX_W = $clog2(RAM_WORDS);

    pipe_pkg::xlen_t mem [RAM_WORDS];
    logic [IDX_W-1:0] ridx;
    logic [IDX_W-1:0] widx;

    logic [RD_LAT-1:0] vld_pipe;
    pipe_pkg::xlen_t   dat_pipe [RD_LAT];

    // double word index, upper address bits wrap
    assign ridx = raddr[3 +: IDX_W];
    assign widx = waddr[3 +: IDX_W];

    initial begin
        for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge I_sys_clk) begin
        if (wen) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    mem[widx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read delay line, valid and data move together
    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_en;
            for (int i = 1; i < RD_LAT; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (rd_en) begin
            dat_pipe[0] <= mem[ridx];
        end
        for (int i = 1; i < RD_LAT; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    assign rvalid = vld_pipe[RD_LAT-1];
    assign rdata  = dat_pipe[RD_LAT-1];

    a_strb_nonzero: assert property (
        @(posedge I_sys_clk) disable iff (I_rst)
        wen |-> (strb != '0)
    ) else $error("store with empty byte strobe");

endmodule

//--- hw/mem_stage.sv
`timescale 1ns/100ps

module mem_stage (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    ex_mem_if.consumer          mem_in,
    input  pipe_pkg::xlen_t     load_data,
    output logic                wen,
    output pipe_pkg::xlen_t     waddr,
    output pipe_pkg::xlen_t     wdata,
    output pipe_pkg::strb_t     strb,
    output logic                out_valid,
    input  logic                out_allowout,
    output pipe_pkg::reg_addr_t out_rd,
    output logic                out_wen,
    output pipe_pkg::xlen_t     out_data
);

    logic            xfer;
    logic [2:0]      offset;
    pipe_pkg::xlen_t shifted;
    pipe_pkg::xlen_t ext_data;
    pipe_pkg::xlen_t wb_data;

    assign mem_in.allowin = !out_valid || out_allowout;
    assign xfer           = mem_in.valid && mem_in.allowin;

    // store is written once, on its way out of EX/MEM
    assign wen   = xfer && (mem_in.op == pipe_pkg::OP_STORE);
    assign waddr = mem_in.result;
    assign wdata = mem_in.st_data;
    assign strb  = mem_in.strb;

    // bring the addressed lane down to bit 0
    assign offset  = pipe_pkg::lane_offset(mem_in.size, mem_in.result[2:0]);
    assign shifted = load_data >> {offset, 3'b000};

    always_comb begin
        case (mem_in.size)
            pipe_pkg::SIZE_B: begin
                ext_data = mem_in.ld_unsigned ? {56'd0, shifted[7:0]}
                                              : {{56{shifted[7]}}, shifted[7:0]};
            end
            pipe_pkg::SIZE_H: begin
                ext_data = mem_in.ld_unsigned ? {48'd0, shifted[15:0]}
                                              : {{48{shifted[15]}}, shifted[15:0]};
            end
            pipe_pkg::SIZE_W: begin
                ext_data = mem_in.ld_unsigned ? {32'd0, shifted[31:0]}
                                              : {{32{shifted[31]}}, shifted[31:0]};
            end
            default: begin
                ext_data = shifted;
            end
        endcase
    end

    // alu ops and stores pass the result field, stores carry their address
    assign wb_data = (mem_in.op == pipe_pkg::OP_LOAD) ? ext_data : mem_in.result;

    always_ff @(posedge I_sys_clk) begin
        if (I_rst) begin
            out_valid <= 1'b0;
        end else if (mem_in.allowin) begin
            out_valid <= mem_in.valid;
        end
    end

    always_ff @(posedge I_sys_clk) begin
        if (xfer) begin
            out_rd   <= mem_in.rd;
            out_wen  <= mem_in.reg_wen;
            out_data <= wb_data;
        end
    end

endmodule

//--- hw/exmem_top.sv
`timescale 1ns/100ps

module exmem_top #(
    parameter int RAM_WORDS = pipe_pkg::RAM_WORDS_DEFAULT,
    parameter int RD_LAT    = pipe_pkg::RD_LAT_DEFAULT
) (
    input  logic                I_sys_clk,
    input  logic                I_rst,
    input  logic                in_valid,
    output logic                in_allowin,
    input  pipe_pkg::alu_op_t   in_op,
    input  pipe_pkg::xlen_t     in_rs1,
    input  pipe_pkg::xlen_t     in_rs2,
    input  pipe_pkg::xlen_t     in_imm,
    input  pipe_pkg::reg_addr_t in_rd,
    input  pipe_pkg::mem_size_t in_size,
    input  logic                in_unsigned,
    output logic                out_valid,
    input  logic                out_allowout,
    output pipe_pkg::reg_addr_t out_rd,
    output logic                out_wen,
    output pipe_pkg::xlen_t     out_data
);

    ex_mem_if ex_if ();
    ex_mem_if mem_if ();

    // data memory port
    logic            rd_en;
    logic            rvalid;
    pipe_pkg::xlen_t rdata;
    pipe_pkg::xlen_t load_data;
    logic            wen;
    pipe_pkg::xlen_t waddr;
    pipe_pkg::xlen_t wdata;
    pipe_pkg::strb_t strb;

    ex_stage ex_stage_i (
        .I_sys_clk   (I_sys_clk),
        .I_rst       (I_rst),
        .in_valid    (in_valid),
        .in_allowin  (in_allowin),
        .in_op       (in_op),
        .in_rs1      (in_rs1),
        .in_rs2      (in_rs2),
        .in_imm      (in_imm),
        .in_rd       (in_rd),
        .in_size     (in_size),
        .in_unsigned (in_unsigned),
        .ex_out      (ex_if.producer)
    );

    ex_mem_reg ex_mem_reg_i (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .ex_in     (ex_if.consumer),
        .mem_out   (mem_if.producer),
        .rd_en     (rd_en),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .load_data (load_data)
    );

    // load address comes straight from the held EX/MEM result
    data_ram #(
        .RAM_WORDS (RAM_WORDS),
        .RD_LAT    (RD_LAT)
    ) data_ram_i (
        .I_sys_clk (I_sys_clk),
        .I_rst     (I_rst),
        .rd_en     (rd_en),
        .raddr     (mem_if.result),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .wen       (wen),
        .waddr     (waddr),
        .wdata     (wdata),
        .strb      (strb)
    );

    mem_stage mem_stage_i (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .mem_in       (mem_if.consumer),
        .load_data    (load_data),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .strb         (strb),
        .out_valid    (out_valid),
        .out_allowout (out_allowout),
        .out_rd       (out_rd),
        .out_wen      (out_wen),
        .out_data     (out_data)
    );

endmodule

//--- sim/tb_exmem.sv
`timescale 1ns/100ps

module tb_exmem;

    localparam int          RD_LAT      = pipe_pkg::RD_LAT_DEFAULT;
    localparam int unsigned MEM_BYTES   = pipe_pkg::RAM_WORDS_DEFAULT * 8;
    localparam int          N_ALU       = 20;
    localparam int          N_LDST      = 45;
    localparam int          N_PART      = 8;
    localparam int          N_RAND      = 150;
    localparam int          N_OPS       = 2 + N_ALU + N_LDST + N_PART + N_RAND;
    localparam int          RESET_NS    = 10 * 10;
    localparam int          WATCHDOG_NS = N_OPS * (RD_LAT + 10) * 10 + RESET_NS;

    // one expected writeback, stores carry their address in data
    typedef struct packed {
        logic                is_store;
        pipe_pkg::reg_addr_t rd;
        pipe_pkg::xlen_t     data;
    } exp_t;

    logic                I_sys_clk;
    logic                I_rst;
    logic                in_valid;
    logic                in_allowin;
    pipe_pkg::alu_op_t   in_op;
    pipe_pkg::xlen_t     in_rs1;
    pipe_pkg::xlen_t     in_rs2;
    pipe_pkg::xlen_t     in_imm;
    pipe_pkg::reg_addr_t in_rd;
    pipe_pkg::mem_size_t in_size;
    logic                in_unsigned;
    logic                out_valid;
    logic                out_allowout;
    pipe_pkg::reg_addr_t out_rd;
    logic                out_wen;
    pipe_pkg::xlen_t     out_data;

    logic [7:0] shadow [MEM_BYTES];
    exp_t       exp_q [$];
    int         n_accepted = 0;
    int         n_checked  = 0;
    logic       bp_on      = 1'b0;
    logic       gaps_on    = 1'b0;

    exmem_top dut_i (
        .I_sys_clk    (I_sys_clk),
        .I_rst        (I_rst),
        .in_valid     (in_valid),
        .in_allowin   (in_allowin),
        .in_op        (in_op),
        .in_rs1       (in_rs1),
        .in_rs2       (in_rs2),
        .in_imm       (in_imm),
        .in_rd        (in_rd),
        .in_size      (in_size),
        .in_unsigned  (in_unsigned),
        .out_valid    (out_valid),
        .out_allowout (out_allowout),
        .out_rd       (out_rd),
        .out_wen      (out_wen),
        .out_data     (out_data)
    );

    initial begin
        I_sys_clk = 1'b0;
        forever #5 I_sys_clk = ~I_sys_clk;
    end

    task automatic report_error(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_wb(input pipe_pkg::reg_addr_t exp_rd, input pipe_pkg::xlen_t exp_data);
        if (out_wen !== 1'b1 || out_rd !== exp_rd || out_data !== exp_data) begin
            report_error($sformatf("writeback rd %0d wen %b data %h, expected rd %0d data %h",
                                   out_rd, out_wen, out_data, exp_rd, exp_data));
        end
    endtask

    task automatic check_store(input pipe_pkg::xlen_t exp_addr);
        if (out_wen !== 1'b0 || out_data !== exp_addr) begin
            report_error($sformatf("store wen %b addr %h, expected wen 0 addr %h",
                                   out_wen, out_data, exp_addr));
        end
    endtask

    // byte-level model of an accepted op, little endian, address wraps at memory size
    function automatic void apply_reference(input pipe_pkg::alu_op_t op,
                                            input pipe_pkg::xlen_t rs1,
                                            input pipe_pkg::xlen_t rs2,
                                            input pipe_pkg::xlen_t imm,
                                            input pipe_pkg::reg_addr_t rd,
                                            input pipe_pkg::mem_size_t size,
                                            input logic uns);
        int unsigned     nbytes;
        int unsigned     base;
        pipe_pkg::xlen_t addr;
        pipe_pkg::xlen_t val;
        exp_t            e;
        nbytes     = 1 << size;
        addr       = rs1 + imm;
        base       = 32'(addr % pipe_pkg::xlen_t'(MEM_BYTES));
        val        = '0;
        e.is_store = 1'b0;
        e.rd       = rd;
        case (op)
            pipe_pkg::OP_ADD: val = rs1 + rs2;
            pipe_pkg::OP_SUB: val = rs1 - rs2;
            pipe_pkg::OP_AND: val = rs1 & rs2;
            pipe_pkg::OP_OR:  val = rs1 | rs2;
            pipe_pkg::OP_XOR: val = rs1 ^ rs2;
            pipe_pkg::OP_LOAD: begin
                for (int i = 0; i < nbytes; i++) begin
                    val[i*8 +: 8] = shadow[(base + i) % MEM_BYTES];
                end
                if (!uns && nbytes < 8 && val[nbytes*8-1]) begin
                    val = val | (~pipe_pkg::xlen_t'(0) << (nbytes * 8));
                end
            end
            default: begin
                for (int i = 0; i < nbytes; i++) begin
                    shadow[(base + i) % MEM_BYTES] = rs2[i*8 +: 8];
                end
                val        = addr;
                e.is_store = 1'b1;
            end
        endcase
        e.data = val;
        exp_q.push_back(e);
    endfunction

    // one clock, then drive a little after the rising edge
    task automatic next_cycle();
        @(posedge I_sys_clk);
        #1;
        out_allowout = bp_on ? (($urandom % 8) < 5) : 1'b1;
    endtask

    task automatic issue(input pipe_pkg::alu_op_t op, input pipe_pkg::xlen_t rs1,
                         input pipe_pkg::xlen_t rs2, input pipe_pkg::xlen_t imm,
                         input pipe_pkg::reg_addr_t rd, input pipe_pkg::mem_size_t size,
                         input logic uns);
        logic taken;
        while (gaps_on && ($urandom % 4) == 0) begin
            next_cycle();
        end
        in_valid    = 1'b1;
        in_op       = op;
        in_rs1      = rs1;
        in_rs2      = rs2;
        in_imm      = imm;
        in_rd       = rd;
        in_size     = size;
        in_unsigned = uns;
        taken       = 1'b0;
        while (!taken) begin
            // allowin is settled by mid cycle
            @(negedge I_sys_clk);
            taken = in_allowin;
            next_cycle();
        end
        in_valid = 1'b0;
    endtask

    // input side, every accepted op feeds the model
    always @(negedge I_sys_clk) begin
        if (!I_rst && in_valid && in_allowin) begin
            apply_reference(in_op, in_rs1, in_rs2, in_imm, in_rd, in_size, in_unsigned);
            n_accepted++;
        end
    end

    always @(negedge I_sys_clk) begin
        exp_t e;
        if (!I_rst && out_valid && out_allowout) begin
            if (exp_q.size() == 0) begin
                report_error("output transfer with no expected result");
            end else begin
                e = exp_q.pop_front();
                if (e.is_store) begin
                    check_store(e.data);
                end else begin
                    check_wb(e.rd, e.data);
                end
                n_checked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        pipe_pkg::alu_op_t   op;
        pipe_pkg::mem_size_t size;
        pipe_pkg::xlen_t     addr;
        pipe_pkg::xlen_t     data;
        pipe_pkg::xlen_t     rs1;
        void'($urandom(32'h58e0c8a7));
        for (int i = 0; i < MEM_BYTES; i++) begin
            shadow[i] = 8'h00;
        end
        I_rst        = 1'b1;
        in_valid     = 1'b0;
        in_op        = pipe_pkg::OP_ADD;
        in_rs1       = '0;
        in_rs2       = '0;
        in_imm       = '0;
        in_rd        = '0;
        in_size      = pipe_pkg::SIZE_D;
        in_unsigned  = 1'b0;
        out_allowout = 1'b1;
        repeat (10) @(posedge I_sys_clk);
        #1;
        I_rst = 1'b0;
        @(negedge I_sys_clk);
        if (out_valid !== 1'b0) begin
            report_error("out_valid is high right after reset");
        end
        next_cycle();

        // never-written top double word reads as zero
        issue(pipe_pkg::OP_LOAD, pipe_pkg::xlen_t'(MEM_BYTES - 8), '0, '0, 5'd1,
              pipe_pkg::SIZE_D, 1'b0);
        issue(pipe_pkg::OP_LOAD, pipe_pkg::xlen_t'(MEM_BYTES - 16), '0, 64'd15, 5'd2,
              pipe_pkg::SIZE_B, 1'b0);

        for (int i = 0; i < N_ALU; i++) begin
            issue(pipe_pkg::alu_op_t'(i % 5), {$urandom, $urandom}, {$urandom, $urandom},
                  {$urandom, $urandom}, 5'($urandom), pipe_pkg::SIZE_D, 1'b0);
        end

        // store then signed and unsigned load, every size and lane
        for (int s = 0; s < 4; s++) begin
            size = pipe_pkg::mem_size_t'(s);
            for (int k = 0; k < (8 >> s); k++) begin
                addr = pipe_pkg::xlen_t'(512 + s * 8 + (k << s));
                data = {$urandom, $urandom};
                data[(8 << s) - 1] = k[0];
                issue(pipe_pkg::OP_STORE, addr, data, '0, 5'($urandom), size, 1'b0);
                issue(pipe_pkg::OP_LOAD, addr, '0, '0, 5'($urandom), size, 1'b0);
                issue(pipe_pkg::OP_LOAD, addr, '0, '0, 5'($urandom), size, 1'b1);
            end
        end

        // partial stores into filled double words
        issue(pipe_pkg::OP_STORE, 64'd1024, 64'h0123_4567_89ab_cdef, '0, 5'd3,
              pipe_pkg::SIZE_D, 1'b0);
        issue(pipe_pkg::OP_STORE, 64'd1000, 64'h5a, 64'd27, 5'd3, pipe_pkg::SIZE_B, 1'b0);
        issue(pipe_pkg::OP_STORE, 64'd1030, 64'hbeef, '0, 5'd3, pipe_pkg::SIZE_H, 1'b0);
        issue(pipe_pkg::OP_LOAD, 64'd1024, '0, '0, 5'd4, pipe_pkg::SIZE_D, 1'b0);
        issue(pipe_pkg::OP_STORE, 64'd1032, 64'hfedc_ba98_7654_3210, '0, 5'd3,
              pipe_pkg::SIZE_D, 1'b0);
        issue(pipe_pkg::OP_STORE, 64'd1036, 64'h1357_9bdf, '0, 5'd3, pipe_pkg::SIZE_W, 1'b0);
        issue(pipe_pkg::OP_LOAD, 64'd1032, '0, '0, 5'd5, pipe_pkg::SIZE_D, 1'b0);
        issue(pipe_pkg::OP_LOAD, 64'd1032, '0, '0, 5'd6, pipe_pkg::SIZE_W, 1'b1);

        // random mix under back-pressure, aligned addresses in a small window
        bp_on   = 1'b1;
        gaps_on = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            op   = pipe_pkg::alu_op_t'($urandom % 7);
            size = pipe_pkg::mem_size_t'($urandom % 4);
            addr = ({$urandom, $urandom} & ~pipe_pkg::xlen_t'(MEM_BYTES - 1))
                   | pipe_pkg::xlen_t'(256 + ($urandom % 16) * 8
                                       + (($urandom % (8 >> size)) << size));
            rs1  = {$urandom, $urandom};
            issue(op, rs1, {$urandom, $urandom}, addr - rs1, 5'($urandom), size, 1'($urandom));
        end
        bp_on   = 1'b0;
        gaps_on = 1'b0;

        while (exp_q.size() != 0) begin
            next_cycle();
        end
        // extra outputs would show up here
        repeat (RD_LAT + 10) next_cycle();

        if (exp_q.size() != 0 || n_accepted != N_OPS || n_checked != N_OPS) begin
            report_error($sformatf("accepted %0d, checked %0d, expected %0d ops",
                                   n_accepted, n_checked, N_OPS));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- sim.f
hw/pipe_pkg.sv
hw/ex_mem_if.sv
hw/ex_stage.sv
hw/ex_mem_reg.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/exmem_top.sv
sim/tb_exmem.sv

//--- Makefile
# Verilator build and run for the EX/MEM slice testbench

VERILATOR ?= verilator
TOP       ?= tb_exmem
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# pass only when the pass message shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
